//--- Bender.yml
package:
  name: itim

sources:
  - rtl/itim_pkg.sv
  - rtl/itim_ram.sv
  - rtl/itim_refill.sv
  - rtl/itim_ctrl.sv
  - rtl/itim.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/backing_mem.sv
      - test/itim_tb.sv

//--- list.f
rtl/itim_pkg.sv
rtl/itim_ram.sv
rtl/itim_refill.sv
rtl/itim_ctrl.sv
rtl/itim.sv
test/clock_gen.sv
test/backing_mem.sv
test/itim_tb.sv

//--- rtl/itim.sv
`timescale 1ns/1ns
`default_nettype none

module itim #(
  parameter logic [31:0] base_addr = 32'h0000_1000,
  parameter logic [31:0] top_addr = 32'h0000_3000
) (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic [31:0] req_addr,
  output logic [63:0] rsp_rdata,
  output logic rsp_ready,
  output logic mem_valid,
  output logic [31:0] mem_addr,
  input logic [31:0] mem_rdata,
  input logic mem_ready
);

  import itim_pkg::*;

  logic fill_start;
  logic [31:0] fill_addr;
  logic fill_done;
  logic [63:0] fill_data;

  logic [itim_banks-1:0] ram_wen;
  logic [itim_banks-1:0][itim_index_bits-1:0] ram_waddr;
  logic [itim_banks-1:0][itim_index_bits-1:0] ram_raddr;
  logic [itim_banks-1:0][itim_line_bits-1:0] ram_wdata;
  logic [itim_banks-1:0][itim_line_bits-1:0] ram_rdata;

  itim_ctrl #(
    .base_addr(base_addr),
    .top_addr(top_addr)
  ) ctrl0 (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_fence(req_fence),
    .req_addr(req_addr),
    .rsp_rdata(rsp_rdata),
    .rsp_ready(rsp_ready),
    .fill_start(fill_start),
    .fill_addr(fill_addr),
    .fill_done(fill_done),
    .fill_data(fill_data),
    .ram_wen(ram_wen),
    .ram_waddr(ram_waddr),
    .ram_raddr(ram_raddr),
    .ram_wdata(ram_wdata),
    .ram_rdata(ram_rdata)
  );

  itim_refill refill0 (
    .clock(clock),
    .reset(reset),
    .fill_start(fill_start),
    .fill_addr(fill_addr),
    .fill_done(fill_done),
    .fill_data(fill_data),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready)
  );

  for (genvar b = 0; b < itim_banks; b++) begin : g_bank
    itim_ram ram0 (
      .clock(clock),
      .wen(ram_wen[b]),
      .waddr(ram_waddr[b]),
      .raddr(ram_raddr[b]),
      .wdata(ram_wdata[b]),
      .rdata(ram_rdata[b])
    );
  end

endmodule

`default_nettype wire

//--- rtl/itim_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module itim_ctrl #(
  parameter logic [31:0] base_addr = 32'h0000_1000,
  parameter logic [31:0] top_addr = 32'h0000_3000
) (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input itim_pkg::itim_addr_u req_addr,
  output logic [63:0] rsp_rdata,
  output logic rsp_ready,
  output logic fill_start,
  output logic [31:0] fill_addr,
  input logic fill_done,
  input logic [63:0] fill_data,
  output logic [itim_pkg::itim_banks-1:0] ram_wen,
  output logic [itim_pkg::itim_banks-1:0][itim_pkg::itim_index_bits-1:0] ram_waddr,
  output logic [itim_pkg::itim_banks-1:0][itim_pkg::itim_index_bits-1:0] ram_raddr,
  output logic [itim_pkg::itim_banks-1:0][itim_pkg::itim_line_bits-1:0] ram_wdata,
  input logic [itim_pkg::itim_banks-1:0][itim_pkg::itim_line_bits-1:0] ram_rdata
);

  import itim_pkg::*;

  typedef enum logic [1:0] {
    st_lookup,
    st_miss,
    st_bypass,
    st_fence
  } state_t;

  state_t state;

  logic req_pending;
  logic req_fence_q;
  itim_addr_u req_q;

  // One count past the last index marks the end of the sweep.
  logic [itim_index_bits:0] sweep;
  logic sweep_end;
  logic fence_rsp;

  logic [itim_line_bits-1:0] line;
  logic line_lock;
  logic [itim_tag_bits-1:0] line_tag;
  logic in_window;
  logic tag_match;
  logic lookup;
  logic go_fence;
  logic go_miss;
  logic go_bypass;
  logic hit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Front stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_pending <= 1'b0;
    end else begin
      req_pending <= req_valid;
    end
  end

  // The request stays put until the next one, so a fill can use it.
  always_ff @(posedge clock) begin
    if (req_valid) begin
      req_fence_q <= req_fence;
      req_q <= req_addr;
    end
  end

  // Both banks read the same index. Only the addressed one is looked at.
  always_comb begin
    for (int b = 0; b < itim_banks; b++) begin
      ram_raddr[b] = req_addr.fields.index;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign line = ram_rdata[req_q.fields.bank];
  assign line_lock = line[itim_line_bits-1];
  assign line_tag = line[itim_line_bits-2 -: itim_tag_bits];

  assign in_window = (req_q.raw >= base_addr) && (req_q.raw < top_addr);
  assign tag_match = (line_tag == req_q.fields.tag);

  assign lookup = (state == st_lookup) && req_pending;

  // Priority is fence, window, lock, then tag.
  assign go_fence = lookup && req_fence_q;
  assign go_bypass = lookup && !req_fence_q &&
                     (!in_window || (line_lock && !tag_match));
  assign go_miss = lookup && !req_fence_q && in_window && !line_lock;
  assign hit = lookup && !req_fence_q && in_window && line_lock && tag_match;

  assign fill_start = go_miss || go_bypass;
  assign fill_addr = {req_q.raw[31:3], 3'b000};

  assign sweep_end = (sweep == itim_lines);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Out of reset the controller sweeps every line once and stays quiet.
  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_fence;
      sweep <= '0;
      fence_rsp <= 1'b0;
    end else begin
      case (state)
        st_lookup: begin
          if (go_fence) begin
            state <= st_fence;
            sweep <= '0;
            fence_rsp <= 1'b1;
          end else if (go_miss) begin
            state <= st_miss;
          end else if (go_bypass) begin
            state <= st_bypass;
          end
        end
        st_miss, st_bypass: begin
          if (fill_done) begin
            state <= st_lookup;
          end
        end
        st_fence: begin
          if (sweep_end) begin
            state <= st_lookup;
          end else begin
            sweep <= sweep + 1'b1;
          end
        end
        default: begin
          state <= st_lookup;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response and line writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    rsp_ready = 1'b0;
    rsp_rdata = '0;
    ram_wen = '0;
    ram_waddr = '0;
    ram_wdata = '0;
    case (state)
      st_lookup: begin
        if (hit) begin
          rsp_ready = 1'b1;
          rsp_rdata = line[63:0];
        end
      end
      st_miss: begin
        // The fetched line is stored locked under the request tag.
        if (fill_done) begin
          rsp_ready = 1'b1;
          rsp_rdata = fill_data;
          ram_wen[req_q.fields.bank] = 1'b1;
          ram_waddr[req_q.fields.bank] = req_q.fields.index;
          ram_wdata[req_q.fields.bank] = {1'b1, req_q.fields.tag, fill_data};
        end
      end
      st_bypass: begin
        if (fill_done) begin
          rsp_ready = 1'b1;
          rsp_rdata = fill_data;
        end
      end
      st_fence: begin
        for (int b = 0; b < itim_banks; b++) begin
          ram_wen[b] = !sweep[itim_index_bits];
          ram_waddr[b] = sweep[itim_index_bits-1:0];
        end
        rsp_ready = sweep_end && fence_rsp;
      end
      default: begin
        rsp_ready = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/itim_pkg.sv
`default_nettype none

package itim_pkg;

  // Two banks of 64 lines. Bit 3 picks the bank and bits 9:4 the line.
  localparam int itim_banks = 2;
  localparam int itim_lines = 64;
  localparam int itim_tag_bits = 22;
  localparam int itim_index_bits = 6;

  // A stored line is {lock, tag, doubleword}.
  localparam int itim_line_bits = 87;

  typedef struct packed {
    logic [itim_tag_bits-1:0] tag;
    logic [itim_index_bits-1:0] index;
    logic bank;
    logic [2:0] offset;
  } itim_addr_fields_t;

  // The fetch address is seen either whole or split into its lookup fields.
  typedef union packed {
    logic [31:0] raw;
    itim_addr_fields_t fields;
  } itim_addr_u;

endpackage

`default_nettype wire

//--- rtl/itim_ram.sv
`timescale 1ns/1ns
`default_nettype none

module itim_ram (
  input logic clock,
  input logic wen,
  input logic [itim_pkg::itim_index_bits-1:0] waddr,
  input logic [itim_pkg::itim_index_bits-1:0] raddr,
  input logic [itim_pkg::itim_line_bits-1:0] wdata,
  output logic [itim_pkg::itim_line_bits-1:0] rdata
);

  import itim_pkg::*;

  logic [itim_line_bits-1:0] lines [itim_lines];
  logic [itim_index_bits-1:0] raddr_q;

  always_ff @(posedge clock) begin
    if (wen) begin
      lines[waddr] <= wdata;
    end
    raddr_q <= raddr;
  end

  // A write to the line being read shows up in the same cycle.
  assign rdata = lines[raddr_q];

endmodule

`default_nettype wire

//--- rtl/itim_refill.sv
`timescale 1ns/1ns
`default_nettype none

module itim_refill (
  input logic clock,
  input logic reset,
  input logic fill_start,
  input logic [31:0] fill_addr,
  output logic fill_done,
  output logic [63:0] fill_data,
  output logic mem_valid,
  output logic [31:0] mem_addr,
  input logic [31:0] mem_rdata,
  input logic mem_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_low,
    st_high
  } state_t;

  state_t state;
  logic [31:0] low_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (fill_start) begin
            state <= st_low;
          end
        end
        st_low: begin
          if (mem_ready) begin
            state <= st_high;
          end
        end
        st_high: begin
          if (mem_ready) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // The address is loaded at the start and steps to the upper word
  // once the low beat has been accepted.
  always_ff @(posedge clock) begin
    if (state == st_idle && fill_start) begin
      mem_addr <= fill_addr;
    end else if (state == st_low && mem_ready) begin
      mem_addr <= mem_addr + 32'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_low && mem_ready) begin
      low_word <= mem_rdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus and result
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign mem_valid = (state != st_idle);

  // The high word goes straight through in the cycle of the last beat.
  assign fill_done = (state == st_high) && mem_ready;
  assign fill_data = {mem_rdata, low_word};

endmodule

`default_nettype wire

//--- test/backing_mem.sv
`timescale 1ns/1ns
`default_nettype none

module backing_mem #(
  parameter int seed_init = 95241,
  parameter int max_delay = 3,
  parameter logic [31:0] data_key = 32'hA5A5_0000
) (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input logic [31:0] mem_addr,
  output logic [31:0] mem_rdata,
  output logic mem_ready,
  output int beats
);

  int seed;
  int wait_left;

  initial begin
    seed = seed_init;
    wait_left = -1;
    beats = 0;
    mem_ready = 1'b0;
    mem_rdata = '0;
  end

  // A beat completes at the edge that ends a cycle with valid and ready.
  always @(negedge clock) begin
    if (mem_valid === 1'b1 && mem_ready === 1'b1) begin
      beats = beats + 1;
    end
  end

  // Each new beat draws its own delay of 0 to max_delay cycles.
  always @(posedge clock) begin
    #1;
    if (reset !== 1'b1 || mem_valid !== 1'b1) begin
      mem_ready = 1'b0;
      wait_left = -1;
    end else begin
      if (wait_left < 0 || mem_ready === 1'b1) begin
        wait_left = $unsigned($random(seed)) % (max_delay + 1);
      end
      if (wait_left == 0) begin
        mem_ready = 1'b1;
        mem_rdata = mem_addr ^ data_key;
      end else begin
        mem_ready = 1'b0;
        wait_left = wait_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
  parameter int period = 8,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // Reset is active low and lifts just after a rising edge.
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/itim_tb.sv
`timescale 1ns/1ns
`default_nettype none

module itim_tb;

  localparam int clock_period = 8;
  localparam int reset_cycles = 16;
  localparam int rand_seed = 95241;
  localparam int max_delay = 3;
  localparam logic [31:0] data_key = 32'hA5A5_0000;
  localparam int n_random = 24;
  localparam int n_requests = 9 + n_random;
  localparam int rsp_limit = 100;
  localparam int req_cycles = 6 + 2 * (max_delay + 1);
  localparam int watchdog_cycles = 2 * (reset_cycles + 90 + 70 + n_requests * req_cycles);

  logic clock;
  logic reset;
  logic req_valid;
  logic req_fence;
  logic [31:0] req_addr;
  logic [63:0] rsp_rdata;
  logic rsp_ready;
  logic mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_rdata;
  logic mem_ready;
  int beats;
  int seed = rand_seed;
  int errors = 0;
  int tests = 0;
  int failed = 0;
  int test_errors;
  string test_name;
  logic [31:0] beat_log [$];
  logic held = 1'b0;
  logic [31:0] held_addr;

  clock_gen #(.period(clock_period), .reset_cycles(reset_cycles)) clock0 (
    .clock(clock),
    .reset(reset)
  );

  backing_mem #(.seed_init(rand_seed), .max_delay(max_delay), .data_key(data_key)) mem0 (
    .clock(clock), .reset(reset), .mem_valid(mem_valid), .mem_addr(mem_addr),
    .mem_rdata(mem_rdata), .mem_ready(mem_ready), .beats(beats)
  );

  itim #(.base_addr(32'h0000_1000), .top_addr(32'h0000_3000)) dut0 (
    .clock(clock), .reset(reset), .req_valid(req_valid), .req_fence(req_fence),
    .req_addr(req_addr), .rsp_rdata(rsp_rdata), .rsp_ready(rsp_ready),
    .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
  );

  function automatic logic [63:0] expected_dword(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return {(base + 32'd4) ^ data_key, base ^ data_key};
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_errors) begin
      $display("test %s: passed", test_name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_errors);
    end
  endtask

  // The latency counts falling edges from the end of the request cycle.
  task automatic send_request(input logic fence, input logic [31:0] addr,
                              output int lat, output logic [63:0] data);
    @(posedge clock);
    #1;
    req_valid = 1'b1;
    req_fence = fence;
    req_addr = addr;
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    req_fence = 1'b0;
    lat = 1;
    @(negedge clock);
    while (rsp_ready !== 1'b1 && lat < rsp_limit) begin
      @(negedge clock);
      lat++;
    end
    data = rsp_rdata;
    if (rsp_ready !== 1'b1) begin
      errors++;
      $display("No response to the request for %h within %0d cycles", addr, rsp_limit);
    end
  endtask

  task automatic check_request(input logic fence, input logic [31:0] addr,
                               input int want_beats, input int want_lat);
    int lat;
    int beats0;
    logic [63:0] data;
    logic [63:0] want_data;
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    want_data = fence ? 64'd0 : expected_dword(addr);
    beats0 = beats;
    beat_log.delete();
    send_request(fence, addr, lat, data);
    @(posedge clock);
    #2;
    assert (data === want_data)
      else report_mismatch($sformatf("data for %h is %h, expected %h", addr, data, want_data));
    if (want_lat > 0) begin
      assert (lat == want_lat)
        else report_mismatch($sformatf("%h answered after %0d cycles, expected %0d",
                                       addr, lat, want_lat));
    end
    if (want_beats >= 0) begin
      assert (beats - beats0 == want_beats)
        else report_mismatch($sformatf("%h made %0d bus beats, expected %0d",
                                       addr, beats - beats0, want_beats));
    end
    if (want_beats == 2) begin
      assert (beat_log.size() == 2 && beat_log[0] == base && beat_log[1] == base + 32'd4)
        else report_mismatch($sformatf("bus beats for %h not at %h and %h",
                                       addr, base, base + 32'd4));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A beat that is still waiting must keep its address on the bus.
  always @(negedge clock) begin
    if (held) begin
      assert (mem_valid === 1'b1 && mem_addr === held_addr)
        else report_mismatch($sformatf("mem_addr moved from %h while waiting", held_addr));
    end
    held = (mem_valid === 1'b1) && (mem_ready !== 1'b1);
    held_addr = mem_addr;
    if (mem_valid === 1'b1 && mem_ready === 1'b1) begin
      beat_log.push_back(mem_addr);
    end
  end

  initial begin
    #(watchdog_cycles * clock_period);
    $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr = '0;
    // The reset sweep takes 65 cycles, so the wait covers it with margin.
    start_test("reset_idle");
    repeat (reset_cycles + 72) begin
      @(negedge clock);
      assert (rsp_ready === 1'b0 && mem_valid === 1'b0)
        else report_mismatch("rsp_ready or mem_valid active before the first request");
    end
    end_test();
    start_test("first_fetch");
    check_request(1'b0, 32'h0000_1238, 2, 0);
    end_test();
    start_test("repeat_hit");
    check_request(1'b0, 32'h0000_1238, 0, 1);
    end_test();
    // 0x1638 shares bank and index with 0x1238 under another tag.
    start_test("bypass");
    repeat (2) begin
      check_request(1'b0, 32'h0000_4010, 2, 0);
      check_request(1'b0, 32'h0000_1638, 2, 0);
    end
    check_request(1'b0, 32'h0000_1238, 0, 1);
    end_test();
    start_test("fence");
    check_request(1'b1, 32'h0000_1238, 0, 66);
    check_request(1'b0, 32'h0000_1238, 2, 0);
    end_test();
    start_test("random_ready");
    repeat (n_random) begin
      check_request(1'b0, 32'h0000_0800 + (($unsigned($random(seed)) % 32'h600) << 3), -1, 0);
    end
    end_test();
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
